//--- design/ts_consts.svh
// line, address, data and descriptor field width macros
`ifndef TS_CONSTS_SVH
`define TS_CONSTS_SVH

// line buffer geometry
`define TS_LINE_W      512
`define TS_X_W         9

// graphics memory bus
`define TS_MADDR_W     21
`define TS_MDATA_W     16

// pixel fields
`define TS_PIX_W       4
`define TS_PAL_W       4

// descriptor fields
`define TS_SIZE_W      3
`define TS_SADDR_W     14
`define TS_ADDR_SHIFT  7
`define TS_CTRL_RSVD_W 29

// words per job from 2 to 16
`define TS_WCNT_W      5

`endif

//--- design/ts_desc_pkg.sv
// descriptor word views, descriptor union and decoded render job
package ts_desc_pkg;

`include "ts_consts.svh"

    // sprite entry with the kind bit low
    typedef struct packed {
        logic                     kind;
        logic [`TS_X_W-1:0]       x;
        logic [`TS_SIZE_W-1:0]    size;
        logic                     flip;
        logic [`TS_PAL_W-1:0]     pal;
        logic [`TS_SADDR_W-1:0]   addr;
    } sprite_desc_t;

    // line control word with the kind bit high
    typedef struct packed {
        logic                       kind;
        logic                       clear;
        logic                       eol;
        logic [`TS_CTRL_RSVD_W-1:0] rsvd;
    } ctrl_desc_t;

    typedef union packed {
        sprite_desc_t sprite;
        ctrl_desc_t   ctrl;
    } desc_word_u;

    // what the renderer needs for one sprite
    typedef struct packed {
        logic [`TS_X_W-1:0]     x;
        logic [`TS_WCNT_W-1:0]  wcnt;
        logic                   flip;
        logic [`TS_PAL_W-1:0]   pal;
        logic [`TS_MADDR_W-1:0] addr;
    } render_job_t;

endpackage

//--- design/ts_mem_pkg.sv
// pixel, line buffer write and graphics memory request types
package ts_mem_pkg;

`include "ts_consts.svh"

    // palette tag in the upper nibble
    typedef struct packed {
        logic [`TS_PAL_W-1:0] pal;
        logic [`TS_PIX_W-1:0] idx;
    } ts_pixel_t;

    // one pixel write into the line buffer
    typedef struct packed {
        logic               en;
        logic [`TS_X_W-1:0] addr;
        ts_pixel_t          pix;
    } lb_write_t;

    // request/next memory request held until next
    typedef struct packed {
        logic                   req;
        logic [`TS_MADDR_W-1:0] addr;
    } mem_req_t;

endpackage

//--- design/ts_desc_decode.sv
// descriptor decoder issuing render jobs, clear pulses and the end of list flag
`include "ts_consts.svh"

module ts_desc_decode
    import ts_desc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        desc_valid,
    output logic        desc_ready,
    input  desc_word_u  desc,
    output logic        job_valid,
    output render_job_t job,
    input  logic        render_busy,
    output logic        clear_start,
    input  logic        clearing,
    output logic        line_done
);

    logic        accept;
    logic        is_ctrl;
    logic        idle;
    logic        eol_pending;
    render_job_t job_d;

    // nothing in flight downstream
    assign idle       = !(job_valid || clear_start || render_busy || clearing);
    assign desc_ready = idle;
    assign accept     = desc_valid && desc_ready;
    assign is_ctrl    = desc.ctrl.kind;
    assign line_done  = eol_pending && idle;

    // sprite view expanded into a job
    always_comb
    begin
        job_d.x    = desc.sprite.x;
        job_d.wcnt = {({1'b0, desc.sprite.size} + 4'd1), 1'b0};
        job_d.flip = desc.sprite.flip;
        job_d.pal  = desc.sprite.pal;
        job_d.addr = `TS_MADDR_W'(desc.sprite.addr) << `TS_ADDR_SHIFT;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            job_valid   <= 1'b0;
            clear_start <= 1'b0;
            eol_pending <= 1'b0;
        end
        else
        begin
            job_valid   <= accept && !is_ctrl;
            clear_start <= accept && is_ctrl && desc.ctrl.clear;
            // any new word ends the previous line
            if (accept)
                eol_pending <= is_ctrl && desc.ctrl.eol;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept && !is_ctrl)
            job <= job_d;
    end

    // renderer must be idle when a job is handed over
    a_job_idle: assert property (@(posedge clk) disable iff (reset)
        job_valid |-> !render_busy);

endmodule

//--- design/ts_render.sv
// sprite renderer with pixel fetch, nibble unpack, flip and opaque pixel writes
`include "ts_consts.svh"

module ts_render
    import ts_desc_pkg::*, ts_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   job_valid,
    input  render_job_t            job,
    output logic                   busy,
    output mem_req_t               mem,
    input  logic [`TS_MDATA_W-1:0] mem_rdata,
    input  logic                   mem_next,
    output lb_write_t              lb_wr
);

    // request side
    logic                   req_r;
    logic                   req_d;
    logic [`TS_MADDR_W-1:0] addr_r;
    logic [`TS_WCNT_W-1:0]  words_left;
    logic [`TS_WCNT_W-1:0]  words_d;

    // unpack side
    logic [`TS_MDATA_W-1:0] cur_data;
    logic                   cur_valid;
    logic [1:0]             nib;
    logic [`TS_MDATA_W-1:0] nxt_data;
    logic                   nxt_valid;
    logic                   nxt_valid_d;
    logic                   unpack_last;
    logic                   cur_free;
    logic [`TS_PIX_W-1:0]   pix_idx;

    // job attributes
    logic [`TS_X_W-1:0]     x_r;
    logic [`TS_X_W-1:0]     x_start;
    logic [`TS_X_W-1:0]     span;
    logic                   flip_r;
    logic [`TS_PAL_W-1:0]   pal_r;

    assign unpack_last = cur_valid && (nib == 2'd3);
    // current word done by the next edge
    assign cur_free    = !cur_valid || unpack_last;
    assign pix_idx     = cur_data[`TS_MDATA_W-1 -: `TS_PIX_W];

    // flipped sprites start at the right edge
    assign span    = `TS_X_W'({job.wcnt, 2'b00} - 7'd1);
    assign x_start = job.flip ? job.x + span : job.x;

    always_comb
    begin
        words_d = words_left;
        if (job_valid)
            words_d = job.wcnt;
        else if (mem_next)
            words_d = words_left - 1'b1;

        nxt_valid_d = nxt_valid;
        if (cur_free && nxt_valid)
            nxt_valid_d = 1'b0;
        else if (!cur_free && mem_next)
            nxt_valid_d = 1'b1;

        // only ask when the hold register has room
        req_d = (words_d != '0) && !nxt_valid_d;
    end

    assign busy     = cur_valid || nxt_valid || (words_left != '0);
    assign mem.req  = req_r;
    assign mem.addr = addr_r;

    always_comb
    begin
        lb_wr.en      = cur_valid && (pix_idx != '0);
        lb_wr.addr    = x_r;
        lb_wr.pix.pal = pal_r;
        lb_wr.pix.idx = pix_idx;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_r      <= 1'b0;
            words_left <= '0;
            nxt_valid  <= 1'b0;
            cur_valid  <= 1'b0;
            nib        <= 2'd0;
        end
        else
        begin
            req_r      <= req_d;
            words_left <= words_d;
            nxt_valid  <= nxt_valid_d;
            if (cur_free && (nxt_valid || mem_next))
            begin
                cur_valid <= 1'b1;
                nib       <= 2'd0;
            end
            else if (cur_valid)
            begin
                nib       <= nib + 1'b1;
                cur_valid <= !unpack_last;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (job_valid)
        begin
            addr_r <= job.addr;
            flip_r <= job.flip;
            pal_r  <= job.pal;
            x_r    <= x_start;
        end
        else
        begin
            if (mem_next)
                addr_r <= addr_r + 1'b1;
            if (cur_valid)
                x_r <= flip_r ? x_r - 1'b1 : x_r + 1'b1;
        end

        // leftmost nibble first
        if (cur_free && nxt_valid)
            cur_data <= nxt_data;
        else if (cur_free && mem_next)
            cur_data <= mem_rdata;
        else if (cur_valid)
            cur_data <= cur_data << `TS_PIX_W;

        if (!cur_free && mem_next)
            nxt_data <= mem_rdata;
    end

    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (mem.req && !mem_next) |=> (mem.req && $stable(mem.addr)));

endmodule

//--- design/ts_line_buf.sv
// line buffer with pixel storage, sequential clear and registered display read port
`include "ts_consts.svh"

module ts_line_buf
    import ts_mem_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               clear_start,
    output logic               clearing,
    input  lb_write_t          lb_wr,
    input  logic [`TS_X_W-1:0] rd_addr,
    output ts_pixel_t          rd_data
);

    ts_pixel_t          line_mem [`TS_LINE_W];
    logic [`TS_X_W-1:0] clr_addr;
    logic               clr_last;

    assign clr_last = (clr_addr == `TS_X_W'(`TS_LINE_W - 1));

    // clear walks one entry per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clearing <= 1'b0;
            clr_addr <= '0;
        end
        else if (clear_start)
        begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end
        else if (clearing)
        begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_last)
                clearing <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (clearing)
            line_mem[clr_addr] <= '0;
        else if (lb_wr.en)
            line_mem[lb_wr.addr] <= lb_wr.pix;
    end

    // display read with one cycle latency
    always_ff @(posedge clk)
    begin
        rd_data <= line_mem[rd_addr];
    end

    // decoder holds jobs off until the clear has run
    a_no_wr_clear: assert property (@(posedge clk) disable iff (reset)
        clearing |-> !lb_wr.en);

endmodule

//--- design/ts_line_top.sv
// line renderer top with descriptor decoder, sprite renderer and line buffer
`include "ts_consts.svh"

module ts_line_top
    import ts_desc_pkg::*, ts_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   desc_valid,
    output logic                   desc_ready,
    input  desc_word_u             desc,
    output mem_req_t               mem,
    input  logic [`TS_MDATA_W-1:0] mem_rdata,
    input  logic                   mem_next,
    input  logic [`TS_X_W-1:0]     rd_addr,
    output ts_pixel_t              rd_data,
    output logic                   line_done
);

    logic        job_valid;
    render_job_t job;
    logic        render_busy;
    logic        clear_start;
    logic        clearing;
    lb_write_t   lb_wr;

    ts_desc_decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .desc_valid  (desc_valid),
        .desc_ready  (desc_ready),
        .desc        (desc),
        .job_valid   (job_valid),
        .job         (job),
        .render_busy (render_busy),
        .clear_start (clear_start),
        .clearing    (clearing),
        .line_done   (line_done)
    );

    ts_render i_render (
        .clk       (clk),
        .reset     (reset),
        .job_valid (job_valid),
        .job       (job),
        .busy      (render_busy),
        .mem       (mem),
        .mem_rdata (mem_rdata),
        .mem_next  (mem_next),
        .lb_wr     (lb_wr)
    );

    ts_line_buf i_line_buf (
        .clk         (clk),
        .reset       (reset),
        .clear_start (clear_start),
        .clearing    (clearing),
        .lb_wr       (lb_wr),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

//--- dv/ts_line_tb.sv
// testbench with memory model, descriptor table, reference line and compare tasks
`include "ts_consts.svh"

module ts_line_tb
    import ts_desc_pkg::*, ts_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED          = 73676;
    localparam int READY_TIMEOUT = 2000;
    localparam int DONE_TIMEOUT  = 2000;
    localparam int MAX_ROWS      = 32;

    typedef struct packed {
        desc_word_u word;
        logic       done_exp;
    } stim_row_t;

    logic                   clk;
    logic                   reset;
    logic                   desc_valid;
    logic                   desc_ready;
    desc_word_u             desc;
    mem_req_t               mem;
    logic [`TS_MDATA_W-1:0] mem_rdata;
    logic                   mem_next;
    logic [`TS_X_W-1:0]     rd_addr;
    ts_pixel_t              rd_data;
    logic                   line_done;

    stim_row_t table_rows [MAX_ROWS];
    int        row_count;
    ts_pixel_t ref_line [`TS_LINE_W];

    ts_line_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .desc       (desc),
        .mem        (mem),
        .mem_rdata  (mem_rdata),
        .mem_next   (mem_next),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .line_done  (line_done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // graphics memory contents as a fixed function of the word address
    function automatic logic [`TS_MDATA_W-1:0] mem_word(input logic [`TS_MADDR_W-1:0] addr);
        logic [31:0] prod;
        prod = 32'(addr) * 32'h0000_9D2B;
        return prod[15:0];
    endfunction

    function automatic desc_word_u sprite_word(input logic [8:0] x, input logic [2:0] size,
                                               input logic flip, input logic [3:0] pal,
                                               input logic [13:0] saddr);
        desc_word_u w;
        w.sprite.kind = 1'b0;
        w.sprite.x    = x;
        w.sprite.size = size;
        w.sprite.flip = flip;
        w.sprite.pal  = pal;
        w.sprite.addr = saddr;
        return w;
    endfunction

    function automatic desc_word_u ctrl_word(input logic clear, input logic eol);
        desc_word_u w;
        w.ctrl.kind  = 1'b1;
        w.ctrl.clear = clear;
        w.ctrl.eol   = eol;
        w.ctrl.rsvd  = '0;
        return w;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic check_pixel(input string name, input ts_pixel_t got, input ts_pixel_t exp);
        if (got !== exp)
        begin
            $display("error %s got 0x%02h expected 0x%02h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error %s got 0x%01h expected 0x%01h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_row(input desc_word_u w, input logic done_exp);
        table_rows[row_count].word     = w;
        table_rows[row_count].done_exp = done_exp;
        row_count++;
    endtask

    task automatic build_table();
        row_count = 0;
        // clear and end of list in one word
        add_row(ctrl_word(1'b1, 1'b1), 1'b1);
        // one unflipped sprite per size code
        add_row(ctrl_word(1'b1, 1'b0), 1'b0);
        add_row(sprite_word(9'd0,   3'd0, 1'b0, 4'h1, 14'h0011), 1'b0);
        add_row(sprite_word(9'd10,  3'd1, 1'b0, 4'h2, 14'h0123), 1'b0);
        add_row(sprite_word(9'd30,  3'd2, 1'b0, 4'h3, 14'h0257), 1'b0);
        add_row(sprite_word(9'd60,  3'd3, 1'b0, 4'h4, 14'h03a1), 1'b0);
        add_row(sprite_word(9'd100, 3'd4, 1'b0, 4'h5, 14'h1004), 1'b0);
        add_row(sprite_word(9'd150, 3'd5, 1'b0, 4'h6, 14'h2b0c), 1'b0);
        add_row(sprite_word(9'd210, 3'd6, 1'b0, 4'h7, 14'h0777), 1'b0);
        add_row(sprite_word(9'd280, 3'd7, 1'b0, 4'h8, 14'h3ffe), 1'b0);
        add_row(ctrl_word(1'b0, 1'b1), 1'b1);
        // flipped sprites with one wrapping past 511
        add_row(ctrl_word(1'b1, 1'b0), 1'b0);
        add_row(sprite_word(9'd490, 3'd3, 1'b1, 4'ha, 14'h0456), 1'b0);
        add_row(sprite_word(9'd20,  3'd1, 1'b1, 4'hb, 14'h1a2b), 1'b0);
        add_row(sprite_word(9'd508, 3'd0, 1'b0, 4'hc, 14'h0c3d), 1'b0);
        add_row(ctrl_word(1'b0, 1'b1), 1'b1);
        // overlap run twice under different memory latency
        for (int n = 0; n < 2; n++)
        begin
            add_row(ctrl_word(1'b1, 1'b0), 1'b0);
            add_row(sprite_word(9'd100, 3'd5, 1'b0, 4'h3, 14'h0321), 1'b0);
            add_row(sprite_word(9'd120, 3'd2, 1'b1, 4'h9, 14'h0c0d), 1'b0);
            add_row(ctrl_word(1'b0, 1'b1), 1'b1);
        end
        // drawn on top of the previous line without a clear
        add_row(sprite_word(9'd300, 3'd7, 1'b1, 4'he, 14'h2222), 1'b0);
        add_row(sprite_word(9'd320, 3'd4, 1'b0, 4'hf, 14'h0040), 1'b0);
        add_row(ctrl_word(1'b0, 1'b1), 1'b1);
    endtask

    // expected line contents from the pixel placement rules
    task automatic apply_to_ref(input desc_word_u w);
        int                     npix;
        int                     pos;
        int                     k;
        int                     a;
        logic [`TS_MADDR_W-1:0] base;
        logic [`TS_MDATA_W-1:0] data;
        logic [3:0]             idx;
        if (w.ctrl.kind)
        begin
            if (w.ctrl.clear)
                for (a = 0; a < `TS_LINE_W; a++)
                    ref_line[a] = '0;
        end
        else
        begin
            npix = (int'(w.sprite.size) + 1) * 8;
            base = `TS_MADDR_W'(w.sprite.addr) << `TS_ADDR_SHIFT;
            for (k = 0; k < npix; k++)
            begin
                data = mem_word(base + `TS_MADDR_W'(k / 4));
                idx  = data[15 - 4 * (k % 4) -: 4];
                if (w.sprite.flip)
                    pos = int'(w.sprite.x) + npix - 1 - k;
                else
                    pos = int'(w.sprite.x) + k;
                pos = pos % `TS_LINE_W;
                if (idx != 4'd0)
                begin
                    ref_line[pos].pal = w.sprite.pal;
                    ref_line[pos].idx = idx;
                end
            end
        end
    endtask

    // returns on the edge that transfers the word
    task automatic send_word(input desc_word_u w);
        int cycles;
        @(posedge clk);
        desc_valid <= 1'b1;
        desc       <= w;
        cycles = 0;
        @(negedge clk);
        while (desc_ready !== 1'b1)
        begin
            cycles++;
            if (cycles > READY_TIMEOUT)
                report_timeout("desc_ready");
            else
                @(negedge clk);
        end
        @(posedge clk);
        desc_valid <= 1'b0;
    endtask

    task automatic wait_line_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (line_done !== 1'b1)
        begin
            cycles++;
            if (cycles > DONE_TIMEOUT)
                report_timeout("line_done after end of list");
            else
                @(negedge clk);
        end
    endtask

    task automatic check_line();
        int a;
        @(posedge clk);
        rd_addr <= '0;
        for (a = 0; a < `TS_LINE_W; a++)
        begin
            // next address goes out while this one comes back
            @(posedge clk);
            rd_addr <= `TS_X_W'(a + 1);
            @(negedge clk);
            check_pixel($sformatf("rd_data[%0d]", a), rd_data, ref_line[a]);
        end
    endtask

    // answers each request after 1 to 6 cycles
    initial
    begin : mem_model
        int                     delay;
        logic [`TS_MADDR_W-1:0] req_addr;
        mem_next  = 1'b0;
        mem_rdata = '0;
        void'($urandom(SEED));
        forever
        begin
            @(negedge clk);
            if (!reset && mem.req)
            begin
                req_addr = mem.addr;
                delay    = int'($urandom_range(6, 1));
                repeat (delay) @(posedge clk);
                mem_next  <= 1'b1;
                mem_rdata <= mem_word(req_addr);
                @(posedge clk);
                mem_next  <= 1'b0;
            end
        end
    end

    initial
    begin : stimulus
        int r;
        reset      = 1'b1;
        desc_valid = 1'b0;
        desc       = '0;
        rd_addr    = '0;
        build_table();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("desc_ready", desc_ready, 1'b1);
        check_flag("mem.req", mem.req, 1'b0);
        check_flag("line_done", line_done, 1'b0);

        for (r = 0; r < row_count; r++)
        begin
            send_word(table_rows[r].word);
            apply_to_ref(table_rows[r].word);
            if (table_rows[r].done_exp)
            begin
                wait_line_done();
                check_line();
                // held until the next descriptor
                check_flag("line_done", line_done, 1'b1);
            end
            else
            begin
                @(negedge clk);
                check_flag("line_done", line_done, 1'b0);
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- list.f
+incdir+design
design/ts_desc_pkg.sv
design/ts_mem_pkg.sv
design/ts_desc_decode.sv
design/ts_render.sv
design/ts_line_buf.sv
design/ts_line_top.sv
dv/ts_line_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ts_line_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST))) $(wildcard design/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
